/* Makefile */
TOP := tb_trigger_agc

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module trigger_agc_top

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
+incdir+logic
logic/agc_pkg.sv
logic/agc_bus_if.sv
logic/sample_decimator.sv
logic/agc_scaler.sv
logic/agc_monitor.sv
logic/agc_loop.sv
logic/trigger_agc_top.sv
verification/tb_trigger_agc.sv

/* logic/agc_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface agc_bus_if;
    import agc_pkg::*;

    logic      cyc;
    logic      stb;
    logic      we;
    bus_addr_t adr;
    bus_word_t dat_w;   // Master to target
    bus_word_t dat_r;   // Target to master, valid with ack
    logic      ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport target (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

/* logic/agc_cfg.svh */
`ifndef AGC_CFG_SVH
`define AGC_CFG_SVH

// Data path geometry
`define AGC_LANES 4
`define AGC_IN_W 12
`define AGC_OUT_W 5

// Gain word formats
`define AGC_SCALE_W 17
`define AGC_OFFSET_W 16
`define AGC_SCALE_FRAC 14

// Measurement window of 2**bits cycles
`define AGC_WINDOW_BITS 6

// Loop targets and dead bands
`define AGC_TARGET_MS 16
`define AGC_MS_ERR 0
`define AGC_OFFSET_ERR 5

// Cutoffs
`define AGC_SCALE_MIN 300
`define AGC_SCALE_MAX 130000
`define AGC_OFFSET_LIM 1000

// Start gain and default steps
`define AGC_START_SCALE 1500
`define AGC_START_OFFSET 0
`define AGC_SCALE_STEP_RST 30
`define AGC_OFFSET_STEP_RST 25

`endif

/* logic/agc_loop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "agc_cfg.svh"

module agc_loop (
    input  wire                     aclk,
    input  wire                     wb_rst_i,
    input  wire                     wb_cyc_i,
    input  wire                     wb_stb_i,
    input  wire                     wb_we_i,
    input  wire agc_pkg::bus_addr_t wb_adr_i,
    input  wire agc_pkg::bus_word_t wb_dat_i,
    output agc_pkg::bus_word_t      wb_dat_o,
    output logic                    wb_ack_o,
    agc_bus_if.master               bus
);
    import agc_pkg::*;

    localparam bus_addr_t READ_MAP [5] = '{8'h04, 8'h08, 8'h0C, 8'h18, 8'h1C};

    loop_state_t state;
    logic [2:0]  idx;            // Access within a state
    logic        enable;
    scale_t      scale_step;
    offset_t     offset_step;
    stat_t       last_ms;
    scale_t      last_scale;
    offset_t     last_offset;
    bus_word_t   cycle_cnt;
    stat_t       rd_sum;
    stat_t       rd_pos;
    stat_t       rd_neg;
    scale_t      rd_scale;
    offset_t     rd_offset;
    stat_t       mean_sq;
    scale_t      next_scale;
    offset_t     next_offset;
    scale_t      calc_scale;
    offset_t     calc_offset;
    logic        op_valid;
    logic        op_we;
    bus_addr_t   op_adr;
    bus_word_t   op_dat;
    logic [1:0]  host_cnt;
    bus_word_t   host_rd;

    // Next internal bus access
    always_comb begin
        op_valid = 1'b1;
        op_we    = 1'b0;
        op_adr   = 8'h00;
        op_dat   = '0;
        case (state)
            LOOP_START: begin
                op_we  = 1'b1;
                op_dat = 32'h1;
            end
            LOOP_POLL: op_adr = 8'h00;
            LOOP_READ: op_adr = READ_MAP[idx];
            LOOP_WRITE: begin
                op_we = 1'b1;
                case (idx)
                    3'd0: begin
                        op_adr = 8'h10;
                        op_dat = bus_word_t'(calc_scale);
                    end
                    3'd1: begin
                        op_adr = 8'h14;
                        op_dat = bus_word_t'(calc_offset);
                    end
                    default: op_dat = 32'h2;   // Apply
                endcase
            end
            default: op_valid = 1'b0;
        endcase
    end

    ////////////////////////////////
    // Step rule
    ////////////////////////////////
    assign mean_sq = rd_sum >> (`AGC_WINDOW_BITS + 2);   // Per sample

    always_comb begin
        next_scale  = rd_scale;
        next_offset = rd_offset;
        if (mean_sq > `AGC_TARGET_MS + `AGC_MS_ERR) begin
            if (rd_scale > `AGC_SCALE_MIN) next_scale = rd_scale - scale_step;
        end else if (mean_sq < `AGC_TARGET_MS - `AGC_MS_ERR) begin
            if (rd_scale < `AGC_SCALE_MAX) next_scale = rd_scale + scale_step;
        end
        if (rd_pos > rd_neg + `AGC_OFFSET_ERR) begin
            if (rd_offset > -`AGC_OFFSET_LIM) next_offset = rd_offset - offset_step;
        end else if (rd_neg > rd_pos + `AGC_OFFSET_ERR) begin
            if (rd_offset < `AGC_OFFSET_LIM) next_offset = rd_offset + offset_step;
        end
    end

    ////////////////////////////////
    // Loop FSM and bus master
    ////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state       <= LOOP_IDLE;
            idx         <= '0;
            bus.cyc     <= 1'b0;
            bus.stb     <= 1'b0;
            bus.we      <= 1'b0;
            last_ms     <= '0;
            last_scale  <= `AGC_START_SCALE;
            last_offset <= `AGC_START_OFFSET;
            cycle_cnt   <= '0;
        end else begin
            if (op_valid && !bus.cyc) begin
                bus.cyc   <= 1'b1;
                bus.stb   <= 1'b1;
                bus.we    <= op_we;
                bus.adr   <= op_adr;
                bus.dat_w <= op_dat;
            end else if (bus.cyc && bus.ack) begin   // Idle one cycle after ack
                bus.cyc <= 1'b0;
                bus.stb <= 1'b0;
                bus.we  <= 1'b0;
            end

            case (state)
                LOOP_IDLE: if (enable) state <= LOOP_START;
                LOOP_START: if (bus.ack) state <= LOOP_POLL;
                LOOP_POLL: begin
                    if (bus.ack && bus.dat_r[1]) begin   // Window done
                        state <= LOOP_READ;
                        idx   <= '0;
                    end
                end
                LOOP_READ: begin
                    if (bus.ack) begin
                        case (idx)
                            3'd0:    rd_sum    <= stat_t'(bus.dat_r);
                            3'd1:    rd_pos    <= stat_t'(bus.dat_r);
                            3'd2:    rd_neg    <= stat_t'(bus.dat_r);
                            3'd3:    rd_scale  <= scale_t'(bus.dat_r);
                            default: rd_offset <= offset_t'(bus.dat_r);
                        endcase
                        if (idx == 3'd4) begin
                            state <= LOOP_CALC;
                            idx   <= '0;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                LOOP_CALC: begin
                    calc_scale  <= next_scale;
                    calc_offset <= next_offset;
                    state       <= LOOP_WRITE;
                end
                LOOP_WRITE: begin
                    if (bus.ack) begin
                        if (idx == 3'd2) begin   // Apply acked, iteration over
                            last_ms     <= mean_sq;
                            last_scale  <= calc_scale;
                            last_offset <= calc_offset;
                            cycle_cnt   <= cycle_cnt + 1'b1;
                            idx         <= '0;
                            state       <= LOOP_IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: state <= LOOP_IDLE;
            endcase
        end
    end

    ////////////////////////////////
    // Host register target
    ////////////////////////////////
    always_comb begin
        case (wb_adr_i)
            8'h00:   host_rd = {31'd0, enable};
            8'h04:   host_rd = bus_word_t'(scale_step);
            8'h08:   host_rd = bus_word_t'(offset_step);
            8'h0C:   host_rd = bus_word_t'(last_ms);
            8'h10:   host_rd = bus_word_t'(last_scale);
            8'h14:   host_rd = bus_word_t'(last_offset);
            8'h18:   host_rd = cycle_cnt;
            default: host_rd = '0;
        endcase
    end

    // Ack on the third edge with cyc and stb
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            enable      <= 1'b1;
            scale_step  <= `AGC_SCALE_STEP_RST;
            offset_step <= `AGC_OFFSET_STEP_RST;
            host_cnt    <= '0;
            wb_ack_o    <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;
            if (wb_cyc_i && wb_stb_i) begin
                if (host_cnt == 2'd2) begin
                    host_cnt <= '0;
                    wb_ack_o <= 1'b1;
                    if (wb_we_i) begin
                        case (wb_adr_i)
                            8'h00: enable      <= wb_dat_i[0];
                            8'h04: scale_step  <= scale_t'(wb_dat_i);
                            8'h08: offset_step <= offset_t'(wb_dat_i);
                            default: ;   // Read only or unmapped
                        endcase
                    end
                end else begin
                    host_cnt <= host_cnt + 1'b1;
                end
            end else begin
                host_cnt <= '0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_cyc_i && wb_stb_i && host_cnt == 2'd2) wb_dat_o <= host_rd;
    end

endmodule

`default_nettype wire

/* logic/agc_monitor.sv */
`timescale 1ns/10ps
`default_nettype none
`include "agc_cfg.svh"

module agc_monitor (
    input  wire                      aclk,
    input  wire                      wb_rst_i,
    input  wire agc_pkg::out_frame_t frame_i,
    agc_bus_if.target                bus,
    output agc_pkg::scale_t          scale_o,
    output agc_pkg::offset_t         offset_o
);
    import agc_pkg::*;

    scale_t    staged_scale;
    offset_t   staged_offset;
    logic      running;
    logic      done;
    logic [`AGC_WINDOW_BITS-1:0] win_cnt;
    stat_t     sum_sq;
    stat_t     pos_cnt;
    stat_t     neg_cnt;
    stat_t     lane_sq;
    stat_t     lane_pos;
    stat_t     lane_neg;
    bus_word_t rd_data;
    logic      req;
    logic      wr;
    logic      ctl_wr;

    assign req    = bus.cyc & bus.stb & ~bus.ack;          // New access
    assign wr     = bus.cyc & bus.stb & bus.ack & bus.we;  // Write commits with ack
    assign ctl_wr = wr & (bus.adr == 8'h00);

    function automatic stat_t lane_square(out_sample_t s);
        logic signed [2*`AGC_OUT_W-1:0] p;
        p = s * s;
        return stat_t'(p);
    endfunction

    // Per cycle contribution of one output frame
    always_comb begin
        lane_sq  = '0;
        lane_pos = '0;
        lane_neg = '0;
        for (int j = 0; j < `AGC_LANES; j++) begin
            lane_sq  = lane_sq + lane_square(frame_i[j]);
            lane_pos = lane_pos + (frame_i[j] > 0);
            lane_neg = lane_neg + (frame_i[j] < 0);
        end
    end

    ////////////////////////////////
    // Measurement window
    ////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            running <= 1'b0;
            done    <= 1'b0;
            win_cnt <= '0;
            sum_sq  <= '0;
            pos_cnt <= '0;
            neg_cnt <= '0;
        end else if (ctl_wr && bus.dat_w[0]) begin
            running <= 1'b1;
            done    <= 1'b0;
            win_cnt <= '0;
            sum_sq  <= '0;
            pos_cnt <= '0;
            neg_cnt <= '0;
        end else if (running) begin
            sum_sq  <= sum_sq + lane_sq;
            pos_cnt <= pos_cnt + lane_pos;
            neg_cnt <= neg_cnt + lane_neg;
            win_cnt <= win_cnt + 1'b1;
            if (&win_cnt) begin   // Last cycle of the window
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    ////////////////////////////////
    // Staged and active gain
    ////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            staged_scale  <= `AGC_START_SCALE;
            staged_offset <= `AGC_START_OFFSET;
            scale_o       <= `AGC_START_SCALE;
            offset_o      <= `AGC_START_OFFSET;
        end else begin
            if (wr && bus.adr == 8'h10) staged_scale  <= scale_t'(bus.dat_w);
            if (wr && bus.adr == 8'h14) staged_offset <= offset_t'(bus.dat_w);
            if (ctl_wr && bus.dat_w[1]) begin   // Apply
                scale_o  <= staged_scale;
                offset_o <= staged_offset;
            end
        end
    end

    always_comb begin
        case (bus.adr)
            8'h00:   rd_data = {30'd0, done, running};
            8'h04:   rd_data = bus_word_t'(sum_sq);
            8'h08:   rd_data = bus_word_t'(pos_cnt);
            8'h0C:   rd_data = bus_word_t'(neg_cnt);
            8'h10:   rd_data = bus_word_t'(staged_scale);
            8'h14:   rd_data = bus_word_t'(staged_offset);   // Sign extended
            8'h18:   rd_data = bus_word_t'(scale_o);
            8'h1C:   rd_data = bus_word_t'(offset_o);
            default: rd_data = '0;
        endcase
    end

    // Single cycle ack, data lands with it
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
        end
    end

    always_ff @(posedge aclk) begin
        if (req) bus.dat_r <= rd_data;
    end

endmodule

`default_nettype wire

/* logic/agc_pkg.sv */
`default_nettype none
`include "agc_cfg.svh"

package agc_pkg;

    // Samples
    typedef logic signed [`AGC_IN_W-1:0]     in_sample_t;
    typedef logic signed [`AGC_OUT_W-1:0]    out_sample_t;
    typedef in_sample_t  [`AGC_LANES-1:0]    in_frame_t;   // Lane j at the low end upward
    typedef out_sample_t [`AGC_LANES-1:0]    out_frame_t;

    // Gain words
    typedef logic        [`AGC_SCALE_W-1:0]  scale_t;      // Unsigned fixed point
    typedef logic signed [`AGC_OFFSET_W-1:0] offset_t;

    // Window statistics and bus words
    typedef logic [23:0] stat_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [7:0]  bus_addr_t;

    typedef enum logic [2:0] {
        LOOP_IDLE,
        LOOP_START,   // Kick off a window
        LOOP_POLL,    // Wait for done
        LOOP_READ,
        LOOP_CALC,
        LOOP_WRITE    // Staged gain then apply
    } loop_state_t;

endpackage

`default_nettype wire

/* logic/agc_scaler.sv */
`timescale 1ns/10ps
`default_nettype none
`include "agc_cfg.svh"

module agc_scaler (
    input  wire                      aclk,
    input  wire                      wb_rst_i,
    input  wire agc_pkg::in_frame_t  frame_i,
    input  wire agc_pkg::scale_t     scale_i,
    input  wire agc_pkg::offset_t    offset_i,
    output agc_pkg::out_frame_t      frame_o
);
    import agc_pkg::*;

    localparam int SUM_W   = `AGC_OFFSET_W + 1;
    localparam int PROD_W  = SUM_W + `AGC_SCALE_W + 1;   // Scale gets a sign bit
    localparam int OUT_MAX = 2**(`AGC_OUT_W-1) - 1;
    localparam int OUT_MIN = -(2**(`AGC_OUT_W-1));

    // Offset, gain, floor shift and saturate for one lane
    function automatic out_sample_t scale_lane(in_sample_t s, scale_t g, offset_t o);
        logic signed [SUM_W-1:0]  sum;
        logic signed [PROD_W-1:0] prod;
        sum  = s + o;
        prod = sum * $signed({1'b0, g});
        prod = prod >>> `AGC_SCALE_FRAC;   // Arithmetic so it floors
        if (prod > OUT_MAX) begin
            return out_sample_t'(OUT_MAX);
        end else if (prod < OUT_MIN) begin
            return out_sample_t'(OUT_MIN);
        end
        return prod[`AGC_OUT_W-1:0];
    endfunction

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            frame_o <= '0;
        end else begin
            for (int j = 0; j < `AGC_LANES; j++) begin
                frame_o[j] <= scale_lane(frame_i[j], scale_i, offset_i);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/sample_decimator.sv */
`timescale 1ns/10ps
`default_nettype none
`include "agc_cfg.svh"

module sample_decimator (
    input  wire                              aclk,
    input  wire                              wb_rst_i,
    input  wire [2*`AGC_LANES*`AGC_IN_W-1:0] dat_i,     // Eight packed samples
    output agc_pkg::in_frame_t               frame_o
);

    // Half rate reduction, even samples only
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            frame_o <= '0;
        end else begin
            for (int k = 0; k < `AGC_LANES; k++) begin
                frame_o[k] <= dat_i[2*k*`AGC_IN_W +: `AGC_IN_W];   // Sample 2k to lane k
            end
        end
    end

endmodule

`default_nettype wire

/* logic/trigger_agc_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "agc_cfg.svh"

module trigger_agc_top (
    input  wire                                aclk,
    input  wire                                wb_rst_i,
    input  wire [2*`AGC_LANES*`AGC_IN_W-1:0]   dat_i,
    output logic [`AGC_LANES*`AGC_OUT_W-1:0]   dat_o,      // Lane j at bits 5j upward
    input  wire                                wb_cyc_i,
    input  wire                                wb_stb_i,
    input  wire                                wb_we_i,
    input  wire [7:0]                          wb_adr_i,
    input  wire [31:0]                         wb_dat_i,
    output logic [31:0]                        wb_dat_o,
    output logic                               wb_ack_o
);
    import agc_pkg::*;

    in_frame_t  dec_frame;
    out_frame_t agc_frame;
    scale_t     act_scale;
    offset_t    act_offset;

    agc_bus_if agc_bus ();   // Loop to monitor

    sample_decimator u_decimator (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .dat_i    (dat_i),
        .frame_o  (dec_frame)
    );

    agc_scaler u_scaler (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .frame_i  (dec_frame),
        .scale_i  (act_scale),
        .offset_i (act_offset),
        .frame_o  (agc_frame)
    );

    agc_monitor u_monitor (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .frame_i  (agc_frame),
        .bus      (agc_bus.target),
        .scale_o  (act_scale),
        .offset_o (act_offset)
    );

    agc_loop u_loop (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .bus      (agc_bus.master)
    );

    assign dat_o = agc_frame;

endmodule

`default_nettype wire

/* verification/tb_trigger_agc.sv */
`timescale 1ns/10ps
`default_nettype none
`include "agc_cfg.svh"

module tb_trigger_agc;
    import agc_pkg::*;

    localparam int IN_BITS         = 2 * `AGC_LANES * `AGC_IN_W;
    localparam int OUT_BITS        = `AGC_LANES * `AGC_OUT_W;
    localparam int OUT_MAX         = 2**(`AGC_OUT_W-1) - 1;
    localparam int OUT_MIN         = -(2**(`AGC_OUT_W-1));
    localparam int HOST_TIMEOUT    = 16;    // Cycles per host access
    localparam int HOST_ACK_EDGE   = 3;     // Ack on the third edge after the request
    localparam int ITER_POLLS      = 200;   // Count reads per loop iteration
    localparam int STABLE_TRIES    = 6;
    localparam int RANDOM_FRAMES   = 48;
    localparam int NEW_SCALE_STEP  = 40;
    localparam int NEW_OFFSET_STEP = 20;
    localparam int STIM_ZERO       = 0;
    localparam int STIM_RANDOM     = 1;
    localparam int STIM_ALT        = 2;     // Full scale, sign flips per frame
    localparam int STIM_CONST      = 3;

    logic                aclk;
    logic                wb_rst_i;
    logic [IN_BITS-1:0]  dat_i;
    logic [OUT_BITS-1:0] dat_o;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    logic [7:0]          wb_adr_i;
    logic [31:0]         wb_dat_i;
    logic [31:0]         wb_dat_o;
    logic                wb_ack_o;
    logic [IN_BITS-1:0]  d1;          // Frame sent one cycle back
    logic [IN_BITS-1:0]  d2;          // Two cycles back, lines up with dat_o
    int                  stim_mode = STIM_ZERO;
    int                  errors = 0;
    int                  checks = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;

    trigger_agc_top dut_i (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .dat_i    (dat_i),
        .dat_o    (dat_o),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Offset, gain with floor, then clamp to the output range
    function automatic out_frame_t expected_frame(input logic [IN_BITS-1:0] f,
                                                  input scale_t sc, input offset_t of);
        out_frame_t r;
        in_sample_t s;
        longint     v;
        for (int j = 0; j < `AGC_LANES; j++) begin
            s = f[2*j*`AGC_IN_W +: `AGC_IN_W];   // Even input samples only
            v = (longint'(s) + longint'(of)) * longint'(sc);
            v = v >>> `AGC_SCALE_FRAC;
            if (v > OUT_MAX) begin
                v = OUT_MAX;
            end else if (v < OUT_MIN) begin
                v = OUT_MIN;
            end
            r[j] = out_sample_t'(v);
        end
        return r;
    endfunction

    //////////////////////////////
    // Frame source
    //////////////////////////////
    initial begin : stimulus
        logic [IN_BITS-1:0] f;
        in_sample_t         smp;
        int unsigned        rng_state;
        bit                 alt_pos;
        int                 frame_no;
        dat_i     = '0;
        d1        = '0;
        d2        = '0;
        rng_state = 9;
        alt_pos   = 1'b1;
        frame_no  = 0;
        forever begin
            @(posedge aclk);
            f = '0;
            for (int k = 0; k < 2*`AGC_LANES; k++) begin
                case (stim_mode)
                    STIM_RANDOM: begin
                        rng_state = lcg_next(rng_state);
                        smp = in_sample_t'(rng_state[27:16]);
                        if (frame_no[0]) smp = smp >>> 4;   // Some frames stay in range
                    end
                    STIM_ALT:   smp = alt_pos ? 12'sd2047 : -12'sd2047;
                    STIM_CONST: smp = 12'sd200;
                    default:    smp = '0;
                endcase
                f[k*`AGC_IN_W +: `AGC_IN_W] = smp;
            end
            alt_pos  = !alt_pos;
            frame_no = frame_no + 1;
            d2    <= d1;
            d1    <= dat_i;
            dat_i <= f;
        end
    end

    task automatic set_stimulus(input int mode);
        stim_mode <= mode;
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_word_at_least(input string name, input bus_word_t got,
                                       input bus_word_t lo);
        checks++;
        if (got < lo) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0d expected at least %0d",
                     $time, name, got, lo);
        end
    endtask

    task automatic check_frame(input string name, input out_frame_t got, input out_frame_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got 0x%05h expected 0x%05h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////
    // Host bus access
    //////////////////////////////
    task automatic wb_access(input logic we, input bus_addr_t adr, input bus_word_t wdat,
                             output bus_word_t rdat);
        int n;
        bit acked;
        n    = 0;
        rdat = '0;
        @(posedge aclk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdat;
        @(negedge aclk);
        while (!wb_ack_o && n < HOST_TIMEOUT) begin
            @(negedge aclk);
            n++;
        end
        acked = wb_ack_o;
        if (!acked) begin
            report_error($sformatf("host bus never acked the access to 0x%02h", adr));
        end else begin
            rdat = wb_dat_o;
            if (n != HOST_ACK_EDGE) begin
                report_error($sformatf("host ack for 0x%02h came on edge %0d instead of %0d",
                                       adr, n, HOST_ACK_EDGE));
            end
        end
        @(posedge aclk);   // Drop the cycle for at least one clock
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(negedge aclk);
        if (acked && wb_ack_o) begin
            report_error($sformatf("host ack for 0x%02h lasted more than one cycle", adr));
        end
    endtask

    task automatic wb_write(input bus_addr_t adr, input bus_word_t wdat);
        bus_word_t unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input bus_addr_t adr, output bus_word_t rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    // Poll the cycle count until the loop finishes one more iteration
    task automatic wait_iteration();
        bus_word_t c0;
        bus_word_t c1;
        int        n;
        n = 0;
        wb_read(8'h18, c0);
        c1 = c0;
        while (c1 == c0 && n < ITER_POLLS) begin
            wb_read(8'h18, c1);
            n++;
        end
        if (c1 == c0) begin
            report_error("loop iteration did not finish in time");
        end else begin
            check_word("cycle count", c1, c0 + 1);
        end
    endtask

    task automatic end_test(input string name, input int err_at_start);
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, errors - err_at_start);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic reset_values_test();
        bus_word_t rd;
        int        e0;
        e0 = errors;
        wb_read(8'h10, rd);
        check_word("applied scale", rd, `AGC_START_SCALE);
        wb_read(8'h14, rd);
        check_word("applied offset", rd, `AGC_START_OFFSET);
        wb_read(8'h00, rd);
        check_word("enable", rd, 32'h1);
        wb_read(8'h04, rd);
        check_word("scale step", rd, `AGC_SCALE_STEP_RST);
        wb_read(8'h08, rd);
        check_word("offset step", rd, `AGC_OFFSET_STEP_RST);
        end_test("reset_values", e0);
    endtask

    task automatic register_access_test();
        bus_word_t rd;
        int        e0;
        e0 = errors;
        wb_write(8'h04, NEW_SCALE_STEP);
        wb_write(8'h08, NEW_OFFSET_STEP);
        wb_read(8'h04, rd);
        check_word("scale step", rd, NEW_SCALE_STEP);
        wb_read(8'h08, rd);
        check_word("offset step", rd, NEW_OFFSET_STEP);
        wb_read(8'h1C, rd);
        check_word("unmapped 0x1c", rd, 32'h0);
        wb_read(8'h40, rd);
        check_word("unmapped 0x40", rd, 32'h0);
        end_test("register_access", e0);
    endtask

    task automatic data_path_test();
        bus_word_t c0;
        bus_word_t c1;
        bus_word_t sc;
        bus_word_t off;
        bit        stable;
        int        tries;
        int        e0;
        e0     = errors;
        stable = 1'b0;
        tries  = 0;
        wb_write(8'h00, 32'h0);
        wb_read(8'h18, c1);
        while (!stable && tries < STABLE_TRIES) begin
            c0 = c1;
            repeat (2 << `AGC_WINDOW_BITS) @(posedge aclk);
            wb_read(8'h18, c1);
            stable = (c1 == c0);
            tries++;
        end
        if (!stable) report_error("loop kept running after enable was cleared");
        wb_read(8'h10, sc);
        wb_read(8'h14, off);
        set_stimulus(STIM_RANDOM);
        repeat (RANDOM_FRAMES) begin
            @(negedge aclk);
            check_frame("dat_o", dat_o, expected_frame(d2, scale_t'(sc), offset_t'(off)));
        end
        end_test("data_path", e0);
    endtask

    task automatic gain_down_test();
        bus_word_t sc_prev;
        bus_word_t sc;
        bus_word_t off;
        bus_word_t ms;
        int        e0;
        e0 = errors;
        set_stimulus(STIM_ALT);
        wb_write(8'h00, 32'h1);
        wait_iteration();   // First window may straddle the pattern change
        wb_read(8'h10, sc_prev);
        wb_read(8'h14, off);
        @(negedge aclk);
        check_frame("dat_o", dat_o, expected_frame(d2, scale_t'(sc_prev), offset_t'(off)));
        repeat (3) begin
            wait_iteration();
            wb_read(8'h0C, ms);
            check_word_at_least("mean square", ms, 225);
            wb_read(8'h10, sc);
            if (sc_prev > `AGC_SCALE_MIN) begin
                check_word("applied scale", sc, sc_prev - NEW_SCALE_STEP);
            end else begin
                check_word("applied scale", sc, sc_prev);
            end
            sc_prev = sc;
        end
        end_test("gain_down", e0);
    endtask

    task automatic gain_up_test();
        bus_word_t sc_prev;
        bus_word_t off_prev;
        bus_word_t sc;
        bus_word_t off;
        bus_word_t ms;
        int        e0;
        e0 = errors;
        set_stimulus(STIM_ZERO);
        wait_iteration();
        wb_read(8'h10, sc_prev);
        wb_read(8'h14, off_prev);
        repeat (3) begin
            wait_iteration();
            wb_read(8'h0C, ms);
            check_word("mean square", ms, 32'h0);
            wb_read(8'h10, sc);
            wb_read(8'h14, off);
            if (sc_prev < `AGC_SCALE_MAX) begin
                check_word("applied scale", sc, sc_prev + NEW_SCALE_STEP);
            end else begin
                check_word("applied scale", sc, sc_prev);
            end
            check_word("applied offset", off, off_prev);   // Counts balance at zero input
            sc_prev = sc;
        end
        end_test("gain_up", e0);
    endtask

    task automatic offset_tracking_test();
        bus_word_t off_prev;
        bus_word_t off;
        int        e0;
        e0 = errors;
        set_stimulus(STIM_CONST);
        wait_iteration();
        wb_read(8'h14, off_prev);
        repeat (3) begin
            wait_iteration();
            wb_read(8'h14, off);
            if ($signed(off_prev) > -`AGC_OFFSET_LIM) begin
                check_word("applied offset", off, off_prev - NEW_OFFSET_STEP);
            end else begin
                check_word("applied offset", off, off_prev);
            end
            off_prev = off;
        end
        end_test("offset_tracking", e0);
    endtask

    initial begin
        wb_rst_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (3) @(posedge aclk);
        wb_rst_i <= 1'b0;
        reset_values_test();
        register_access_test();
        data_path_test();
        gain_down_test();
        gain_up_test();
        offset_tracking_test();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
